// ==== rtl/sxt_param_pkg.sv ====
package sxt_param_pkg;

  // ----------------------------------------
  // Polynomial and register file sizes
  // ----------------------------------------
  localparam int COEF_W       = 16;
  localparam int POLY_N       = 32;
  localparam int REGF_COEF_NB = 4;
  localparam int WORD_NB      = POLY_N / REGF_COEF_NB;

  // Derived widths
  localparam int GRAM_ADD_W   = $clog2(POLY_N);
  localparam int BODY_W       = $clog2(2 * POLY_N);
  localparam int REGF_WORD_W  = REGF_COEF_NB * COEF_W;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [COEF_W-1:0]      coef_t;
  typedef logic [GRAM_ADD_W-1:0]  gram_add_t;
  // Rotation amount, taken modulo 2*POLY_N
  typedef logic [BODY_W-1:0]      body_t;
  typedef logic [REGF_WORD_W-1:0] regf_word_t;

endpackage

// ==== rtl/sxt_cmd_pkg.sv ====
package sxt_cmd_pkg;

  // ----------------------------------------
  // Command fields
  // ----------------------------------------
  localparam int PID_W   = 4;
  localparam int REGID_W = 4;

  typedef logic [PID_W-1:0]   pid_t;
  typedef logic [REGID_W-1:0] regid_t;

  // Control FSM, one sequence at a time
  typedef enum logic [2:0] {
    IDLE,
    WAIT_BODY,
    REQ,
    READ,
    WAIT_ACK,
    DONE
  } ctrl_state_t;

endpackage

// ==== rtl/sxt_ctrl.sv ====
`timescale 1ns/1ns

module sxt_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,

  input  sxt_cmd_pkg::pid_t     cmd_pid,
  input  sxt_cmd_pkg::regid_t   cmd_regid,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,

  input  sxt_param_pkg::body_t  body,
  input  logic                  body_vld,
  output logic                  body_rdy,

  output logic                  wr_req_vld,
  input  logic                  wr_req_rdy,
  output sxt_cmd_pkg::regid_t   wr_req_regid,

  output logic                  rd_start,
  output sxt_param_pkg::body_t  body_q,
  input  logic                  word_last,
  input  logic                  wr_ack,

  output logic                  seq_done,
  output sxt_cmd_pkg::pid_t     seq_done_pid,

  output logic                  wait_body_dur,
  output logic                  req_dur,
  output logic                  rcp_dur
);

  sxt_cmd_pkg::ctrl_state_t state;
  sxt_cmd_pkg::ctrl_state_t state_next;
  sxt_cmd_pkg::pid_t        pid_q;
  sxt_cmd_pkg::regid_t      regid_q;
  logic                     body_held;
  logic                     cmd_take;
  logic                     body_take;

  // ----------------------------------------
  // Command and body join
  // ----------------------------------------
  assign cmd_rdy   = (state == sxt_cmd_pkg::IDLE);
  // A body may come first, it is then held until the command shows up
  assign body_rdy  = ((state == sxt_cmd_pkg::IDLE) && !body_held) ||
                     (state == sxt_cmd_pkg::WAIT_BODY);
  assign cmd_take  = cmd_vld && cmd_rdy;
  assign body_take = body_vld && body_rdy;

  always_comb begin
    state_next = state;
    case (state)
      sxt_cmd_pkg::IDLE: begin
        if (cmd_take) begin
          state_next = (body_held || body_take) ? sxt_cmd_pkg::REQ : sxt_cmd_pkg::WAIT_BODY;
        end
      end
      sxt_cmd_pkg::WAIT_BODY: if (body_take) state_next = sxt_cmd_pkg::REQ;
      sxt_cmd_pkg::REQ:       if (wr_req_rdy) state_next = sxt_cmd_pkg::READ;
      sxt_cmd_pkg::READ:      if (word_last) state_next = sxt_cmd_pkg::WAIT_ACK;
      sxt_cmd_pkg::WAIT_ACK:  if (wr_ack) state_next = sxt_cmd_pkg::DONE;
      default:                state_next = sxt_cmd_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= sxt_cmd_pkg::IDLE;
      body_held <= 1'b0;
      rd_start  <= 1'b0;
    end else begin
      state     <= state_next;
      body_held <= (state == sxt_cmd_pkg::IDLE) && !cmd_take && (body_held || body_take);
      // Read starts the cycle after the request is taken
      rd_start  <= (state == sxt_cmd_pkg::REQ) && wr_req_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      pid_q   <= cmd_pid;
      regid_q <= cmd_regid;
    end
    if (body_take) begin
      body_q <= body;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign wr_req_vld    = (state == sxt_cmd_pkg::REQ);
  assign wr_req_regid  = regid_q;
  assign seq_done      = (state == sxt_cmd_pkg::DONE);
  assign seq_done_pid  = pid_q;

  assign wait_body_dur = (state == sxt_cmd_pkg::WAIT_BODY);
  assign req_dur       = (state == sxt_cmd_pkg::REQ);
  assign rcp_dur       = (state == sxt_cmd_pkg::READ) || (state == sxt_cmd_pkg::WAIT_ACK);

endmodule

// ==== rtl/sxt_gram.sv ====
`timescale 1ns/1ns

module sxt_gram #(
  parameter int DATA_LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     wr_en,
  input  sxt_param_pkg::gram_add_t wr_add,
  input  sxt_param_pkg::coef_t     wr_data,

  input  logic                     rd_en,
  input  sxt_param_pkg::gram_add_t rd_add,
  output sxt_param_pkg::coef_t     rd_data,
  output logic                     rd_data_avail
);

  sxt_param_pkg::coef_t    mem       [sxt_param_pkg::POLY_N];
  sxt_param_pkg::coef_t    data_pipe [DATA_LATENCY];
  logic [DATA_LATENCY-1:0] avail_pipe;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_add] <= wr_data;
    end
  end

  // ----------------------------------------
  // Read pipeline, DATA_LATENCY stages
  // ----------------------------------------
  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[rd_add];
    for (int i = 1; i < DATA_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      avail_pipe <= '0;
    end else begin
      avail_pipe[0] <= rd_en;
      for (int i = 1; i < DATA_LATENCY; i++) begin
        avail_pipe[i] <= avail_pipe[i-1];
      end
    end
  end

  assign rd_data       = data_pipe[DATA_LATENCY-1];
  assign rd_data_avail = avail_pipe[DATA_LATENCY-1];

endmodule

// ==== rtl/sxt_rotate.sv ====
`timescale 1ns/1ns

module sxt_rotate #(
  parameter int DATA_LATENCY = 2,
  parameter int CREDIT_NB    = 7
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     rd_start,
  input  sxt_param_pkg::body_t     body_q,

  output logic                     rd_en,
  output sxt_param_pkg::gram_add_t rd_add,
  input  sxt_param_pkg::coef_t     rd_data,
  input  logic                     rd_data_avail,

  output sxt_param_pkg::coef_t     coef_out,
  output logic                     coef_out_vld,
  input  logic                     slot_free
);

  localparam int CREDIT_W = $clog2(CREDIT_NB + 1);

  logic                     active;
  sxt_param_pkg::gram_add_t j_cnt;
  sxt_param_pkg::body_t     k_idx;
  sxt_param_pkg::gram_add_t k_low;
  logic                     k_wrap;
  logic [DATA_LATENCY-1:0]  wrap_pipe;
  logic [CREDIT_W-1:0]      credit;

  // ----------------------------------------
  // Address generation
  // ----------------------------------------
  assign rd_en  = active && (credit != '0);

  // k = j + b, wraps at 2*POLY_N in the body width
  assign k_idx  = sxt_param_pkg::body_t'(j_cnt) + body_q;
  assign k_wrap = k_idx[sxt_param_pkg::BODY_W-1];
  assign k_low  = k_idx[sxt_param_pkg::GRAM_ADD_W-1:0];
  // Reverse storage order in GRAM
  assign rd_add = sxt_param_pkg::gram_add_t'(sxt_param_pkg::POLY_N - 1) - k_low;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      j_cnt  <= '0;
    end else if (rd_start) begin
      active <= 1'b1;
      j_cnt  <= '0;
    end else if (rd_en) begin
      j_cnt <= j_cnt + 1'b1;
      if (j_cnt == sxt_param_pkg::gram_add_t'(sxt_param_pkg::POLY_N - 1)) begin
        active <= 1'b0;
      end
    end
  end

  // Wrap flag follows the read through the RAM latency
  always_ff @(posedge clk) begin
    wrap_pipe[0] <= k_wrap;
    for (int i = 1; i < DATA_LATENCY; i++) begin
      wrap_pipe[i] <= wrap_pipe[i-1];
    end
  end

  // Credits mirror the free slots in the packer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit <= CREDIT_W'(CREDIT_NB);
    end else begin
      credit <= credit - CREDIT_W'(rd_en) + CREDIT_W'(slot_free);
    end
  end

  // ----------------------------------------
  // Negation on return
  // ----------------------------------------
  assign coef_out     = wrap_pipe[DATA_LATENCY-1] ? sxt_param_pkg::coef_t'(-rd_data) : rd_data;
  assign coef_out_vld = rd_data_avail;

endmodule

// ==== rtl/sxt_pack.sv ====
`timescale 1ns/1ns

module sxt_pack #(
  parameter int DEPTH = 7
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  sxt_param_pkg::coef_t      coef_out,
  input  logic                      coef_out_vld,
  output logic                      slot_free,

  output logic                      wr_data_vld,
  input  logic                      wr_data_rdy,
  output sxt_param_pkg::regf_word_t wr_data,
  output logic                      word_last
);

  localparam int NB     = sxt_param_pkg::REGF_COEF_NB;
  localparam int CW     = sxt_param_pkg::COEF_W;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int WCNT_W = $clog2(sxt_param_pkg::WORD_NB + 1);

  sxt_param_pkg::coef_t fifo [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fill;
  logic [CNT_W-1:0]     free_pend;
  logic [WCNT_W-1:0]    word_cnt;
  logic                 word_acc;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int inc);
    int sum;
    sum = int'(ptr) + inc;
    if (sum >= DEPTH) begin
      sum = sum - DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  assign wr_data_vld = (fill >= CNT_W'(NB));
  assign word_acc    = wr_data_vld && wr_data_rdy;
  assign word_last   = word_acc && (word_cnt == WCNT_W'(sxt_param_pkg::WORD_NB - 1));
  assign slot_free   = (free_pend != '0);

  // Oldest coefficient in the lowest lane
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      wr_data[i*CW +: CW] = fifo[ptr_add(rd_ptr, i)];
    end
  end

  always_ff @(posedge clk) begin
    if (coef_out_vld) begin
      fifo[wr_ptr] <= coef_out;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      free_pend <= '0;
      word_cnt  <= '0;
    end else begin
      if (coef_out_vld) wr_ptr <= ptr_add(wr_ptr, 1);
      if (word_acc) rd_ptr <= ptr_add(rd_ptr, NB);
      fill      <= fill + CNT_W'(coef_out_vld) - (word_acc ? CNT_W'(NB) : '0);
      // Slots go back to the rotator one per cycle
      free_pend <= free_pend + (word_acc ? CNT_W'(NB) : '0) - CNT_W'(slot_free);
      if (word_acc) begin
        word_cnt <= word_last ? '0 : word_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/sxt_main.sv ====
`timescale 1ns/1ns

module sxt_main #(
  parameter int DATA_LATENCY = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  sxt_cmd_pkg::pid_t         cmd_pid,
  input  sxt_cmd_pkg::regid_t       cmd_regid,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,

  input  sxt_param_pkg::body_t      body,
  input  logic                      body_vld,
  output logic                      body_rdy,

  input  logic                      gram_wr_en,
  input  sxt_param_pkg::gram_add_t  gram_wr_add,
  input  sxt_param_pkg::coef_t      gram_wr_data,

  output logic                      wr_req_vld,
  input  logic                      wr_req_rdy,
  output sxt_cmd_pkg::regid_t       wr_req_regid,

  output logic                      wr_data_vld,
  input  logic                      wr_data_rdy,
  output sxt_param_pkg::regf_word_t wr_data,
  input  logic                      wr_ack,

  output logic                      seq_done,
  output sxt_cmd_pkg::pid_t         seq_done_pid,

  output logic                      wait_body_dur,
  output logic                      req_dur,
  output logic                      rcp_dur
);

  // Packer room matches the reads that can be in flight
  localparam int PACK_DEPTH = DATA_LATENCY + sxt_param_pkg::REGF_COEF_NB + 1;

  logic                     rd_start;
  sxt_param_pkg::body_t     body_q;
  logic                     rd_en;
  sxt_param_pkg::gram_add_t rd_add;
  sxt_param_pkg::coef_t     rd_data;
  logic                     rd_data_avail;
  sxt_param_pkg::coef_t     coef_out;
  logic                     coef_out_vld;
  logic                     slot_free;
  logic                     word_last;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  sxt_ctrl sxt_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_pid       (cmd_pid),
    .cmd_regid     (cmd_regid),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .body          (body),
    .body_vld      (body_vld),
    .body_rdy      (body_rdy),
    .wr_req_vld    (wr_req_vld),
    .wr_req_rdy    (wr_req_rdy),
    .wr_req_regid  (wr_req_regid),
    .rd_start      (rd_start),
    .body_q        (body_q),
    .word_last     (word_last),
    .wr_ack        (wr_ack),
    .seq_done      (seq_done),
    .seq_done_pid  (seq_done_pid),
    .wait_body_dur (wait_body_dur),
    .req_dur       (req_dur),
    .rcp_dur       (rcp_dur)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  sxt_gram #(
    .DATA_LATENCY (DATA_LATENCY)
  ) sxt_gram_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_en         (gram_wr_en),
    .wr_add        (gram_wr_add),
    .wr_data       (gram_wr_data),
    .rd_en         (rd_en),
    .rd_add        (rd_add),
    .rd_data       (rd_data),
    .rd_data_avail (rd_data_avail)
  );

  sxt_rotate #(
    .DATA_LATENCY (DATA_LATENCY),
    .CREDIT_NB    (PACK_DEPTH)
  ) sxt_rotate_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_start      (rd_start),
    .body_q        (body_q),
    .rd_en         (rd_en),
    .rd_add        (rd_add),
    .rd_data       (rd_data),
    .rd_data_avail (rd_data_avail),
    .coef_out      (coef_out),
    .coef_out_vld  (coef_out_vld),
    .slot_free     (slot_free)
  );

  sxt_pack #(
    .DEPTH (PACK_DEPTH)
  ) sxt_pack_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .coef_out     (coef_out),
    .coef_out_vld (coef_out_vld),
    .slot_free    (slot_free),
    .wr_data_vld  (wr_data_vld),
    .wr_data_rdy  (wr_data_rdy),
    .wr_data      (wr_data),
    .word_last    (word_last)
  );

endmodule

// ==== verification/sxt_checker.sv ====
`timescale 1ns/1ns

module sxt_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_vld,
  input  logic                      cmd_rdy,
  input  logic                      body_vld,
  input  logic                      body_rdy,
  input  logic                      wr_req_vld,
  input  logic                      wr_req_rdy,
  input  sxt_cmd_pkg::regid_t       wr_req_regid,
  input  logic                      wr_data_vld,
  input  logic                      wr_data_rdy,
  input  sxt_param_pkg::regf_word_t wr_data,
  input  logic                      wr_ack,
  input  logic                      seq_done,
  input  sxt_cmd_pkg::pid_t         seq_done_pid,
  input  logic                      wait_body_dur,
  input  logic                      req_dur,
  input  logic                      rcp_dur,
  output int                        err_cnt,
  output int                        done_cnt
);

  localparam int N       = sxt_param_pkg::POLY_N;
  localparam int NB      = sxt_param_pkg::REGF_COEF_NB;
  localparam int CW      = sxt_param_pkg::COEF_W;
  localparam int WORD_NB = sxt_param_pkg::WORD_NB;
  localparam int REC_W   = N + 3;
  localparam int REC_NB  = 4;

  logic [15:0]               rec_mem [REC_NB*REC_W];
  int                        rec;
  int                        word_idx;
  logic                      rec_ok;
  logic                      cmd_seen;
  logic                      req_seen;
  logic                      body_pend;
  logic                      req_pend;
  logic                      rcp_pend;
  logic                      ack_q;
  sxt_param_pkg::regf_word_t exp_word;
  sxt_cmd_pkg::regid_t       exp_regid;
  sxt_cmd_pkg::pid_t         exp_pid;

  initial begin
    $readmemh("verification/sxt_testdata.txt", rec_mem);
  end

  // ----------------------------------------
  // Reference model of the rotation
  // ----------------------------------------
  function automatic sxt_param_pkg::regf_word_t expected_word(input int r, input int w);
    sxt_param_pkg::regf_word_t word;
    int          b;
    int          j;
    int          k;
    int          i;
    logic [CW-1:0] c;
    word = '0;
    b = int'(rec_mem[r*REC_W]);
    for (i = 0; i < NB; i++) begin
      j = w * NB + i;
      k = (j + b) % (2 * N);
      if (k < N) begin
        c = rec_mem[r*REC_W + 3 + k];
      end else begin
        // Two's complement negation modulo 2^COEF_W
        c = CW'((1 << CW) - int'(rec_mem[r*REC_W + 3 + k - N]));
      end
      word[i*CW +: CW] = c;
    end
    return word;
  endfunction

  task automatic compare_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("FAIL %0t ns %s expected %0b actual %0b", $time, name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  // ----------------------------------------
  // Monitor sampled on the rising edge
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      err_cnt   = 0;
      done_cnt  = 0;
      rec       = -1;
      word_idx  = 0;
      cmd_seen  = 1'b0;
      req_seen  = 1'b0;
      body_pend = 1'b0;
      req_pend  = 1'b0;
      rcp_pend  = 1'b0;
      ack_q     = 1'b0;
    end else begin
      if (!cmd_seen && (seq_done || wr_data_vld || wr_req_vld)) begin
        $display("ERROR at %0t ns: DUT output active before any command", $time);
        err_cnt++;
      end
      compare_bit("wait_body_dur", body_pend, wait_body_dur);
      compare_bit("req_dur", req_pend, req_dur);
      compare_bit("wr_req_vld", req_pend, wr_req_vld);
      compare_bit("rcp_dur", rcp_pend, rcp_dur);
      // Done must follow the acknowledge by one cycle
      compare_bit("seq_done", ack_q, seq_done);

      if (cmd_vld && cmd_rdy) begin
        rec       = rec + 1;
        cmd_seen  = 1'b1;
        req_seen  = 1'b0;
        word_idx  = 0;
        body_pend = 1'b1;
      end
      if (body_vld && body_rdy) begin
        if (body_pend) begin
          req_pend = 1'b1;
        end
        body_pend = 1'b0;
      end
      rec_ok = (rec >= 0) && (rec < REC_NB);

      if (wr_req_vld && wr_req_rdy && rec_ok) begin
        exp_regid = rec_mem[rec*REC_W + 2][sxt_cmd_pkg::REGID_W-1:0];
        if (wr_req_regid !== exp_regid) begin
          $display("FAIL %0t ns wr_req_regid expected %h actual %h",
                   $time, exp_regid, wr_req_regid);
          err_cnt++;
        end
        req_seen = 1'b1;
        req_pend = 1'b0;
        rcp_pend = 1'b1;
      end

      if (wr_data_vld && wr_data_rdy && rec_ok) begin
        if (!req_seen) begin
          $display("ERROR at %0t ns: data word arrived before the write request", $time);
          err_cnt++;
        end else if (word_idx >= WORD_NB) begin
          $display("ERROR at %0t ns: more than %0d data words in one sequence",
                   $time, WORD_NB);
          err_cnt++;
        end else begin
          exp_word = expected_word(rec, word_idx);
          if (wr_data !== exp_word) begin
            $display("FAIL %0t ns wr_data expected %h actual %h", $time, exp_word, wr_data);
            err_cnt++;
          end
        end
        word_idx++;
      end

      if (seq_done) begin
        if (rec_ok) begin
          exp_pid = rec_mem[rec*REC_W + 1][sxt_cmd_pkg::PID_W-1:0];
          if (seq_done_pid !== exp_pid) begin
            $display("FAIL %0t ns seq_done_pid expected %h actual %h",
                     $time, exp_pid, seq_done_pid);
            err_cnt++;
          end
          if (word_idx != WORD_NB) begin
            $display("ERROR at %0t ns: sequence ended after %0d of %0d words",
                     $time, word_idx, WORD_NB);
            err_cnt++;
          end
        end
        if (done_cnt != rec) begin
          $display("ERROR at %0t ns: seq_done seen more than once for one command", $time);
          err_cnt++;
        end
        done_cnt++;
      end
      if (wr_ack) begin
        rcp_pend = 1'b0;
      end
      ack_q = wr_ack;
    end
  end

endmodule

// ==== verification/tb_sxt_main.sv ====
`timescale 1ns/1ns

module tb_sxt_main;

  localparam int N       = sxt_param_pkg::POLY_N;
  localparam int WORD_NB = sxt_param_pkg::WORD_NB;
  localparam int REC_W   = N + 3;
  localparam int REC_NB  = 4;
  localparam int TIMEOUT = 2000;

  logic                      clk;
  logic                      rst_n;
  sxt_cmd_pkg::pid_t         cmd_pid;
  sxt_cmd_pkg::regid_t       cmd_regid;
  logic                      cmd_vld;
  logic                      cmd_rdy;
  sxt_param_pkg::body_t      body;
  logic                      body_vld;
  logic                      body_rdy;
  logic                      gram_wr_en;
  sxt_param_pkg::gram_add_t  gram_wr_add;
  sxt_param_pkg::coef_t      gram_wr_data;
  logic                      wr_req_vld;
  logic                      wr_req_rdy;
  sxt_cmd_pkg::regid_t       wr_req_regid;
  logic                      wr_data_vld;
  logic                      wr_data_rdy;
  sxt_param_pkg::regf_word_t wr_data;
  logic                      wr_ack;
  logic                      seq_done;
  sxt_cmd_pkg::pid_t         seq_done_pid;
  logic                      wait_body_dur;
  logic                      req_dur;
  logic                      rcp_dur;

  logic [15:0] rec_mem [REC_NB*REC_W];
  logic [31:0] rng_state;
  int          words_seen;
  int          timeout_cnt;
  int          chk_err_cnt;
  int          chk_done_cnt;
  int          r;

  sxt_main #(
    .DATA_LATENCY (2)
  ) sxt_main_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_pid       (cmd_pid),
    .cmd_regid     (cmd_regid),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .body          (body),
    .body_vld      (body_vld),
    .body_rdy      (body_rdy),
    .gram_wr_en    (gram_wr_en),
    .gram_wr_add   (gram_wr_add),
    .gram_wr_data  (gram_wr_data),
    .wr_req_vld    (wr_req_vld),
    .wr_req_rdy    (wr_req_rdy),
    .wr_req_regid  (wr_req_regid),
    .wr_data_vld   (wr_data_vld),
    .wr_data_rdy   (wr_data_rdy),
    .wr_data       (wr_data),
    .wr_ack        (wr_ack),
    .seq_done      (seq_done),
    .seq_done_pid  (seq_done_pid),
    .wait_body_dur (wait_body_dur),
    .req_dur       (req_dur),
    .rcp_dur       (rcp_dur)
  );

  sxt_checker sxt_checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .body_vld      (body_vld),
    .body_rdy      (body_rdy),
    .wr_req_vld    (wr_req_vld),
    .wr_req_rdy    (wr_req_rdy),
    .wr_req_regid  (wr_req_regid),
    .wr_data_vld   (wr_data_vld),
    .wr_data_rdy   (wr_data_rdy),
    .wr_data       (wr_data),
    .wr_ack        (wr_ack),
    .seq_done      (seq_done),
    .seq_done_pid  (seq_done_pid),
    .wait_body_dur (wait_body_dur),
    .req_dur       (req_dur),
    .rcp_dur       (rcp_dur),
    .err_cnt       (chk_err_cnt),
    .done_cnt      (chk_done_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ----------------------------------------
  // Random back-pressure on the outputs
  // ----------------------------------------
  initial begin
    rng_state   = 32'hf7148d85;
    wr_req_rdy  = 1'b0;
    wr_data_rdy = 1'b0;
    forever begin
      @(negedge clk);
      rng_state   = lcg_next(rng_state);
      wr_req_rdy  = rng_state[28];
      // Data ready about three quarters of the time
      wr_data_rdy = (rng_state[31:30] != 2'b00);
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      words_seen <= 0;
    end else if (wr_data_vld && wr_data_rdy) begin
      words_seen <= words_seen + 1;
    end
  end

  // Coefficient k lands at address POLY_N-1-k
  task automatic load_gram(input int rec);
    int k;
    for (k = 0; k < N; k++) begin
      @(negedge clk);
      gram_wr_en   = 1'b1;
      gram_wr_add  = sxt_param_pkg::gram_add_t'(N - 1 - k);
      gram_wr_data = rec_mem[rec*REC_W + 3 + k];
    end
    @(negedge clk);
    gram_wr_en = 1'b0;
  endtask

  task automatic drive_command(input int rec, input int delay);
    int   cnt;
    logic taken;
    @(negedge clk);
    cmd_pid   = rec_mem[rec*REC_W + 1][sxt_cmd_pkg::PID_W-1:0];
    cmd_regid = rec_mem[rec*REC_W + 2][sxt_cmd_pkg::REGID_W-1:0];
    cmd_vld   = 1'b1;
    taken     = 1'b0;
    cnt       = 0;
    while (!taken && cnt < TIMEOUT) begin
      @(posedge clk);
      taken = cmd_rdy;
      cnt++;
    end
    @(negedge clk);
    cmd_vld = 1'b0;
    if (!taken) begin
      $display("ERROR at %0t ns: timeout waiting for cmd_rdy", $time);
      timeout_cnt++;
    end else begin
      // Body follows the command after a gap
      repeat (delay - 1) @(negedge clk);
      body     = rec_mem[rec*REC_W][sxt_param_pkg::BODY_W-1:0];
      body_vld = 1'b1;
      taken    = 1'b0;
      cnt      = 0;
      while (!taken && cnt < TIMEOUT) begin
        @(posedge clk);
        taken = body_rdy;
        cnt++;
      end
      @(negedge clk);
      body_vld = 1'b0;
      if (!taken) begin
        $display("ERROR at %0t ns: timeout waiting for body_rdy", $time);
        timeout_cnt++;
      end
    end
  endtask

  task automatic wait_words(input int target);
    int cnt;
    cnt = 0;
    while (words_seen < target && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (words_seen < target) begin
      $display("ERROR at %0t ns: timeout waiting for data words, got %0d of %0d",
               $time, words_seen, target);
      timeout_cnt++;
    end
  endtask

  task automatic pulse_ack();
    repeat (3) @(negedge clk);
    wr_ack = 1'b1;
    @(negedge clk);
    wr_ack = 1'b0;
  endtask

  task automatic wait_seq_done();
    int   cnt;
    logic seen;
    seen = 1'b0;
    cnt  = 0;
    while (!seen && cnt < TIMEOUT) begin
      @(posedge clk);
      seen = seq_done;
      cnt++;
    end
    if (!seen) begin
      $display("ERROR at %0t ns: timeout waiting for seq_done", $time);
      timeout_cnt++;
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_n        = 1'b0;
    cmd_pid      = '0;
    cmd_regid    = '0;
    cmd_vld      = 1'b0;
    body         = '0;
    body_vld     = 1'b0;
    gram_wr_en   = 1'b0;
    gram_wr_add  = '0;
    gram_wr_data = '0;
    wr_ack       = 1'b0;
    timeout_cnt  = 0;
    $readmemh("verification/sxt_testdata.txt", rec_mem);

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet period with no outputs expected
    repeat (8) @(negedge clk);

    for (r = 0; r < REC_NB && timeout_cnt == 0; r++) begin
      load_gram(r);
      drive_command(r, 1 + 3 * r);
      if (timeout_cnt == 0) begin
        wait_words((r + 1) * WORD_NB);
      end
      if (timeout_cnt == 0) begin
        pulse_ack();
        wait_seq_done();
      end
    end
    repeat (4) @(negedge clk);

    if (chk_done_cnt != REC_NB) begin
      $display("ERROR: %0d of %0d sequences completed", chk_done_cnt, REC_NB);
    end
    $display("Errors: %0d check, %0d timeout, sequences done %0d of %0d",
             chk_err_cnt, timeout_cnt, chk_done_cnt, REC_NB);
    if (chk_err_cnt == 0 && timeout_cnt == 0 && chk_done_cnt == REC_NB) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/sxt_testdata.txt ====
// Record: b pid regid, then coefficients k = 0 .. POLY_N-1 (hex)
// Four records of 35 words each
00 3 5
1a2b 0001 7fff 8000 ffff 1234 4c3d 9e0f
0a11 0b22 0c33 0d44 0e55 0f66 1077 1188
2468 1357 abcd ef01 0000 5a5a a5a5 3c3c
c3c3 6e7f 7e6f 0102 fedc 4321 8765 0fed
05 a 1
f001 e102 d203 c304 b405 a506 9607 8708
7809 690a 5a0b 4b0c 3c0d 2d0e 1e0f 0f10
1111 2222 3333 4444 5555 6666 7777 8888
9999 aaaa bbbb cccc dddd eeee 0002 fffe
2b 6 c
0100 0200 0300 0400 0500 0600 0700 0800
0900 0a00 0b00 0c00 0d00 0e00 0f00 1000
c001 c002 c003 c004 c005 c006 c007 c008
c009 c00a c00b c00c c00d c00e c00f c010
3f f 7
3141 5926 5358 9793 2384 6264 3383 2795
0288 4197 1693 9937 5105 8209 7494 4592
3078 1640 6286 2089 9862 8034 8253 4211
7067 9821 4808 6513 2823 0664 7093 8446

// ==== sxt.f ====
rtl/sxt_param_pkg.sv
rtl/sxt_cmd_pkg.sv
rtl/sxt_ctrl.sv
rtl/sxt_gram.sv
rtl/sxt_rotate.sv
rtl/sxt_pack.sv
rtl/sxt_main.sv
verification/sxt_checker.sv
verification/tb_sxt_main.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_sxt_main -f sxt.f -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "^Test passed$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
